// ==== vlog.f ====
design/cpu_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/regfile.sv
design/execute_unit.sv
design/hazard_unit.sv
design/memory_unit.sv
design/cpu_top.sv
bench/tb_clock.sv
bench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_top -f vlog.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
  import cpu_pkg::*;

  localparam word_t reset_pc   = 32'h1c000000;
  localparam word_t data_base  = 32'h00010000;
  localparam int    imem_words = 512;
  localparam int    dmem_words = 64;
  localparam int    body_len   = 150;
  localparam int    idle_limit = 200;

  logic      clk;
  logic      reset;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  trace_t    trace;
  word_t     imem_off;
  word_t     dmem_off;

  word_t     imem [imem_words];
  word_t     dmem [dmem_words];
  int        prog_len;
  trace_t    exp_trace[$];
  dmem_req_t exp_store[$];

  tb_clock #(.period(8.0)) u_clock (.clk(clk));

  cpu_top #(
    .reset_pc(reset_pc)
  ) dut (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dmem_req  (dmem_req),
    .dmem_rdata(dmem_rdata),
    .trace     (trace)
  );

  function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9e3779b1) ^ 32'h5a5a0ff0;
  endfunction

  // both memories answer combinationally
  assign imem_off = (imem_addr - reset_pc) >> 2;
  assign dmem_off = (dmem_req.addr - data_base) >> 2;

  always_comb begin
    imem_data  = (imem_off < 32'(imem_words)) ? imem[imem_off[8:0]] : '0;
    dmem_rdata = (dmem_off < 32'(dmem_words)) ? dmem[dmem_off[5:0]] : '0;
  end

  always @(posedge clk) begin : dmem_write
    int k;
    if (reset) begin
      for (k = 0; k < dmem_words; k++) begin
        dmem[k[5:0]] <= fill_word(data_base + 32'(4 * k));
      end
    end else if (dmem_req.we && dmem_off < 32'(dmem_words)) begin
      dmem[dmem_off[5:0]] <= dmem_req.wdata;
    end
  end

  function automatic word_t enc_3r(logic [16:0] op, reg_addr_t rk, reg_addr_t rj, reg_addr_t rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic word_t enc_2ri12(logic [9:0] op, logic [11:0] si12, reg_addr_t rj,
                                     reg_addr_t rd);
    return {op, si12, rj, rd};
  endfunction

  function automatic word_t enc_lu12i(logic [19:0] si20, reg_addr_t rd);
    return {op_lu12i_w[16:10], si20, rd};
  endfunction

  function automatic word_t enc_b(logic [25:0] offs);
    return {op_b[16:11], offs[15:0], offs[25:16]};
  endfunction

  function automatic reg_addr_t any_src();
    return reg_addr_t'($urandom_range(15, 0));
  endfunction

  // r1 holds the data base, so it is never a destination
  function automatic reg_addr_t any_dest();
    reg_addr_t r;
    r = reg_addr_t'($urandom_range(15, 1));
    if (r == 5'd1) r = 5'd0;
    return r;
  endfunction

  function automatic logic [16:0] any_3r_op();
    case ($urandom_range(4, 0))
      0: return op_add_w;
      1: return op_sub_w;
      2: return op_and;
      3: return op_or;
      default: return op_xor;
    endcase
  endfunction

  function automatic void emit(word_t inst);
    imem[prog_len[8:0]] = inst;
    prog_len++;
  endfunction

  function automatic void build_program();
    int          r;
    int          skip;
    reg_addr_t   ra;
    reg_addr_t   rb;
    logic [11:0] off;
    prog_len = 0;
    emit(enc_lu12i(data_base[31:12], 5'd1));
    for (r = 2; r < 16; r++) begin
      emit(enc_lu12i(20'($urandom), 5'(r)));
      emit(enc_2ri12(op_addi_w[16:7], 12'($urandom), 5'(r), 5'(r)));
    end
    while (prog_len < body_len) begin
      off  = 12'(4 * $urandom_range(63, 0));
      skip = $urandom_range(3, 1);
      ra   = any_src();
      rb   = ($urandom_range(1, 0) == 0) ? ra : any_src();
      case ($urandom_range(9, 0))
        0, 1, 2: emit(enc_3r(any_3r_op(), any_src(), any_src(), any_dest()));
        3: emit(enc_2ri12(op_addi_w[16:7], 12'($urandom), any_src(), any_dest()));
        4: emit(enc_lu12i(20'($urandom), any_dest()));
        5: emit(enc_2ri12(op_ld_w[16:7], off, 5'd1, any_dest()));
        6: emit(enc_2ri12(op_st_w[16:7], off, 5'd1, any_src()));
        7: begin
          // store, reload and use right away
          ra = any_dest();
          emit(enc_2ri12(op_st_w[16:7], off, 5'd1, rb));
          emit(enc_2ri12(op_ld_w[16:7], off, 5'd1, ra));
          emit(enc_3r(op_add_w, ra, ra, any_dest()));
        end
        8: begin
          if ($urandom_range(1, 0) == 0) begin
            emit({op_beq[16:11], 16'(skip + 1), ra, rb});
          end else begin
            emit({op_bne[16:11], 16'(skip + 1), ra, rb});
          end
        end
        default: emit(enc_b(26'(skip + 1)));
      endcase
    end
    // landing pad for the last branches, all writing r0
    for (r = 0; r < 3; r++) begin
      emit(enc_2ri12(op_addi_w[16:7], 12'd1, 5'd2, 5'd0));
    end
    emit(enc_b(26'd0));
  endfunction

  // ISA level model that fills the expected queues
  function automatic void run_reference();
    word_t     regs [32];
    word_t     mem [dmem_words];
    word_t     pc;
    word_t     next_pc;
    word_t     inst;
    word_t     src_a;
    word_t     src_b;
    word_t     src_d;
    word_t     si12;
    word_t     br16;
    word_t     res;
    word_t     off;
    logic      wr;
    int        k;
    trace_t    ev;
    dmem_req_t st;
    for (k = 0; k < 32; k++) regs[k[4:0]] = '0;
    for (k = 0; k < dmem_words; k++) mem[k[5:0]] = fill_word(data_base + 32'(4 * k));
    pc = reset_pc;
    for (k = 0; k < 10000; k++) begin
      off  = (pc - reset_pc) >> 2;
      inst = imem[off[8:0]];
      if (inst == enc_b(26'd0)) break;
      src_a   = regs[inst[9:5]];
      src_b   = regs[inst[14:10]];
      src_d   = regs[inst[4:0]];
      si12    = {{20{inst[21]}}, inst[21:10]};
      br16    = {{14{inst[25]}}, inst[25:10], 2'b00};
      next_pc = pc + 32'd4;
      wr      = 1'b1;
      res     = '0;
      if (inst[31:15] == op_add_w) res = src_a + src_b;
      else if (inst[31:15] == op_sub_w) res = src_a - src_b;
      else if (inst[31:15] == op_and) res = src_a & src_b;
      else if (inst[31:15] == op_or) res = src_a | src_b;
      else if (inst[31:15] == op_xor) res = src_a ^ src_b;
      else if (inst[31:22] == op_addi_w[16:7]) res = src_a + si12;
      else if (inst[31:25] == op_lu12i_w[16:10]) res = {inst[24:5], 12'h000};
      else if (inst[31:22] == op_ld_w[16:7]) begin
        off = (src_a + si12 - data_base) >> 2;
        res = mem[off[5:0]];
      end else begin
        wr = 1'b0;
        if (inst[31:22] == op_st_w[16:7]) begin
          off = (src_a + si12 - data_base) >> 2;
          mem[off[5:0]] = src_d;
          st.we    = 1'b1;
          st.addr  = src_a + si12;
          st.wdata = src_d;
          exp_store.push_back(st);
        end else if (inst[31:26] == op_beq[16:11]) begin
          if (src_a == src_d) next_pc = pc + br16;
        end else if (inst[31:26] == op_bne[16:11]) begin
          if (src_a != src_d) next_pc = pc + br16;
        end else if (inst[31:26] == op_b[16:11]) begin
          next_pc = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
      end
      if (wr && inst[4:0] != 5'd0) begin
        regs[inst[4:0]] = res;
        ev.we    = 1'b1;
        ev.pc    = pc;
        ev.wnum  = inst[4:0];
        ev.wdata = res;
        exp_trace.push_back(ev);
      end
      pc = next_pc;
    end
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(string name, word_t got, word_t want);
    if (got !== want) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic check_trace();
    trace_t want;
    if (exp_trace.size() == 0) begin
      $display("register write to r%0d at pc %h was not expected", trace.wnum, trace.pc);
      abort_run();
    end else begin
      want = exp_trace.pop_front();
      if (trace.pc < reset_pc) begin
        $display("retired pc %h lies below the reset pc", trace.pc);
        abort_run();
      end
      check_value("trace.pc", trace.pc, want.pc);
      check_value("trace.wnum", 32'(trace.wnum), 32'(want.wnum));
      check_value("trace.wdata", trace.wdata, want.wdata);
    end
  endtask

  task automatic check_store();
    dmem_req_t want;
    if (exp_store.size() == 0) begin
      $display("store to %h was not expected", dmem_req.addr);
      abort_run();
    end else begin
      want = exp_store.pop_front();
      check_value("dmem_req.addr", dmem_req.addr, want.addr);
      check_value("dmem_req.wdata", dmem_req.wdata, want.wdata);
    end
  endtask

  // outputs settle mid-cycle
  always @(negedge clk) begin
    if (reset) begin
      check_value("trace.we", 32'(trace.we), 32'd0);
      check_value("dmem_req.we", 32'(dmem_req.we), 32'd0);
    end else begin
      if (trace.we) check_trace();
      if (dmem_req.we) check_store();
    end
  end

  initial begin
    int i;
    int idle;
    int pending;
    int last_pending;
    void'($urandom(32'h5094af14));
    reset = 1'b1;
    for (i = 0; i < imem_words; i++) imem[i[8:0]] = '0;
    build_program();
    run_reference();
    $display("%0d instructions, %0d register writes and %0d stores expected",
             prog_len, exp_trace.size(), exp_store.size());
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;

    idle         = 0;
    last_pending = exp_trace.size() + exp_store.size();
    while (exp_trace.size() + exp_store.size() != 0) begin
      @(posedge clk);
      pending = exp_trace.size() + exp_store.size();
      if (pending != last_pending) begin
        idle         = 0;
        last_pending = pending;
      end else begin
        idle++;
      end
      if (idle > idle_limit) begin
        $display("timeout: no retirement arrived within %0d cycles, %0d events outstanding",
                 idle_limit, pending);
        abort_run();
      end
    end
    // give a stray write time to show up
    repeat (20) @(posedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter real period = 8.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
  parameter cpu_pkg::word_t reset_pc = 32'h1c000000
) (
  input  logic               clk,
  input  logic               reset,
  output cpu_pkg::word_t     imem_addr,
  input  cpu_pkg::word_t     imem_data,
  output cpu_pkg::dmem_req_t dmem_req,
  input  cpu_pkg::word_t     dmem_rdata,
  output cpu_pkg::trace_t    trace
);
  import cpu_pkg::*;

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   wb;
  reg_addr_t rf_raddr1;
  reg_addr_t rf_raddr2;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  logic      br_taken;
  word_t     br_target;
  logic      stall;
  logic      bubble;
  logic      flush;
  fwd_sel_e  fwd_sel_a;
  fwd_sel_e  fwd_sel_b;

  fetch_unit #(
    .reset_pc(reset_pc)
  ) u_fetch (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .flush    (flush),
    .br_taken (br_taken),
    .br_target(br_target),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .if_id    (if_id)
  );

  decode_unit u_decode (
    .clk      (clk),
    .reset    (reset),
    .bubble   (bubble),
    .flush    (flush),
    .if_id    (if_id),
    .rf_raddr1(rf_raddr1),
    .rf_raddr2(rf_raddr2),
    .rf_rdata1(rf_rdata1),
    .rf_rdata2(rf_rdata2),
    .id_ex    (id_ex)
  );

  regfile u_regfile (
    .clk      (clk),
    .rf_raddr1(rf_raddr1),
    .rf_raddr2(rf_raddr2),
    .rf_rdata1(rf_rdata1),
    .rf_rdata2(rf_rdata2),
    .wb       (wb)
  );

  execute_unit u_execute (
    .clk      (clk),
    .reset    (reset),
    .id_ex    (id_ex),
    .fwd_sel_a(fwd_sel_a),
    .fwd_sel_b(fwd_sel_b),
    .wb       (wb),
    .ex_mem   (ex_mem),
    .br_taken (br_taken),
    .br_target(br_target)
  );

  memory_unit u_memory (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .dmem_req  (dmem_req),
    .dmem_rdata(dmem_rdata),
    .wb        (wb),
    .trace     (trace)
  );

  hazard_unit u_hazard (
    .id_ex    (id_ex),
    .if_id    (if_id),
    .ex_mem   (ex_mem),
    .wb       (wb),
    .br_taken (br_taken),
    .stall    (stall),
    .bubble   (bubble),
    .flush    (flush),
    .fwd_sel_a(fwd_sel_a),
    .fwd_sel_b(fwd_sel_b)
  );

endmodule

// ==== design/memory_unit.sv ====
`timescale 1ns/1ps

module memory_unit (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::ex_mem_t   ex_mem,
  output cpu_pkg::dmem_req_t dmem_req,
  input  cpu_pkg::word_t     dmem_rdata,
  output cpu_pkg::mem_wb_t   wb,
  output cpu_pkg::trace_t    trace
);
  import cpu_pkg::*;

  word_t mem_result;

  assign dmem_req.we    = ex_mem.valid && ex_mem.mem_we;
  assign dmem_req.addr  = ex_mem.result;
  assign dmem_req.wdata = ex_mem.st_data;

  // word loads only, no lane select
  assign mem_result = ex_mem.load ? dmem_rdata : ex_mem.result;

  always_ff @(posedge clk) begin
    wb.pc     <= ex_mem.pc;
    wb.result <= mem_result;
    wb.rf_we  <= ex_mem.rf_we;
    wb.dest   <= ex_mem.dest;
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= ex_mem.valid;
    end
  end

  assign trace.we    = wb.valid && wb.rf_we;
  assign trace.pc    = wb.pc;
  assign trace.wnum  = wb.dest;
  assign trace.wdata = wb.result;

  // a store never also writes the register file
  store_valid: assert property (@(posedge clk) disable iff (reset)
    dmem_req.we |-> !ex_mem.rf_we);

endmodule

// ==== design/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::if_id_t   if_id,
  input  cpu_pkg::ex_mem_t  ex_mem,
  input  cpu_pkg::mem_wb_t  wb,
  input  logic              br_taken,
  output logic              stall,
  output logic              bubble,
  output logic              flush,
  output cpu_pkg::fwd_sel_e fwd_sel_a,
  output cpu_pkg::fwd_sel_e fwd_sel_b
);
  import cpu_pkg::*;

  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  logic      load_use;

  // memory stage is younger, so it wins
  function automatic fwd_sel_e pick(reg_addr_t src, ex_mem_t mem, mem_wb_t wbs);
    if (src == '0) return fwd_rf;
    if (mem.valid && mem.rf_we && mem.dest == src) return fwd_mem;
    if (wbs.valid && wbs.rf_we && wbs.dest == src) return fwd_wb;
    return fwd_rf;
  endfunction

  always_comb begin
    dec_rs1 = if_id.inst[9:5];
    if (if_id.inst[31:22] == op_st_w[16:7] || if_id.inst[31:26] == op_beq[16:11]
        || if_id.inst[31:26] == op_bne[16:11]) begin
      dec_rs2 = if_id.inst[4:0];
    end else begin
      dec_rs2 = if_id.inst[14:10];
    end

    load_use = id_ex.valid && id_ex.load && id_ex.rf_we && if_id.valid
             && (id_ex.dest == dec_rs1 || id_ex.dest == dec_rs2);
    flush  = br_taken;
    stall  = load_use && !flush;
    bubble = load_use;

    fwd_sel_a = pick(id_ex.rj, ex_mem, wb);
    fwd_sel_b = pick(id_ex.rs2, ex_mem, wb);

    // a load in execute is never also a taken branch
    assert (!(bubble && flush)) else $error("bubble issued during a branch flush");
  end

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::fwd_sel_e fwd_sel_a,
  input  cpu_pkg::fwd_sel_e fwd_sel_b,
  input  cpu_pkg::mem_wb_t  wb,
  output cpu_pkg::ex_mem_t  ex_mem,
  output logic              br_taken,
  output cpu_pkg::word_t    br_target
);
  import cpu_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_src2;
  word_t alu_result;
  logic  br_cond;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val,
                                    word_t mem_val, word_t wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    op_a     = fwd_mux(fwd_sel_a, id_ex.rj_val, ex_mem.result, wb.result);
    op_b     = fwd_mux(fwd_sel_b, id_ex.rkd_val, ex_mem.result, wb.result);
    alu_src2 = id_ex.src2_is_imm ? id_ex.imm : op_b;
  end

  always_comb begin
    case (id_ex.alu_op)
      alu_sub: alu_result = op_a - alu_src2;
      alu_and: alu_result = op_a & alu_src2;
      alu_or:  alu_result = op_a | alu_src2;
      alu_xor: alu_result = op_a ^ alu_src2;
      // imm already holds si20 << 12
      alu_lui: alu_result = alu_src2;
      default: alu_result = op_a + alu_src2;
    endcase
  end

  always_comb begin
    case (id_ex.br_kind)
      br_beq:  br_cond = (op_a == op_b);
      br_bne:  br_cond = (op_a != op_b);
      br_b:    br_cond = 1'b1;
      default: br_cond = 1'b0;
    endcase
  end

  assign br_taken  = id_ex.valid && br_cond;
  assign br_target = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk) begin
    ex_mem.pc      <= id_ex.pc;
    ex_mem.result  <= alu_result;
    ex_mem.st_data <= op_b;
    ex_mem.rf_we   <= id_ex.rf_we;
    ex_mem.mem_we  <= id_ex.mem_we;
    ex_mem.load    <= id_ex.load;
    ex_mem.dest    <= id_ex.dest;
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.valid;
    end
  end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
  input  logic               clk,
  input  cpu_pkg::reg_addr_t rf_raddr1,
  input  cpu_pkg::reg_addr_t rf_raddr2,
  output cpu_pkg::word_t     rf_rdata1,
  output cpu_pkg::word_t     rf_rdata2,
  input  cpu_pkg::mem_wb_t   wb
);
  import cpu_pkg::*;

  word_t regs [32];

  // write-first, so decode sees the value retiring this cycle
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) return '0;
    if (wb.valid && wb.rf_we && wb.dest == addr) return wb.result;
    return regs[addr];
  endfunction

  always_comb begin
    rf_rdata1 = read_port(rf_raddr1);
    rf_rdata2 = read_port(rf_raddr2);
  end

  always_ff @(posedge clk) begin
    if (wb.valid && wb.rf_we) begin
      regs[wb.dest] <= wb.result;
    end
  end

  // decode drops rf_we for r0 destinations
  no_r0_write: assert property (@(posedge clk) !(wb.valid && wb.rf_we && wb.dest == '0));

endmodule

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               bubble,
  input  logic               flush,
  input  cpu_pkg::if_id_t    if_id,
  output cpu_pkg::reg_addr_t rf_raddr1,
  output cpu_pkg::reg_addr_t rf_raddr2,
  input  cpu_pkg::word_t     rf_rdata1,
  input  cpu_pkg::word_t     rf_rdata2,
  output cpu_pkg::id_ex_t    id_ex
);
  import cpu_pkg::*;

  word_t     inst;
  reg_addr_t rd;
  reg_addr_t rj;
  reg_addr_t rk;
  logic      is_add, is_sub, is_and, is_or, is_xor;
  logic      is_addi, is_lu12i, is_ld, is_st;
  logic      is_beq, is_bne, is_b;
  logic      known;
  logic      src2_is_rd;
  id_ex_t    id_ex_d;

  assign inst = if_id.inst;
  assign rd   = inst[4:0];
  assign rj   = inst[9:5];
  assign rk   = inst[14:10];

  // 3R ops fix all of 31..15, the rest only a prefix
  assign is_add   = inst[31:15] == op_add_w;
  assign is_sub   = inst[31:15] == op_sub_w;
  assign is_and   = inst[31:15] == op_and;
  assign is_or    = inst[31:15] == op_or;
  assign is_xor   = inst[31:15] == op_xor;
  assign is_addi  = inst[31:22] == op_addi_w[16:7];
  assign is_lu12i = inst[31:25] == op_lu12i_w[16:10];
  assign is_ld    = inst[31:22] == op_ld_w[16:7];
  assign is_st    = inst[31:22] == op_st_w[16:7];
  assign is_beq   = inst[31:26] == op_beq[16:11];
  assign is_bne   = inst[31:26] == op_bne[16:11];
  assign is_b     = inst[31:26] == op_b[16:11];

  assign known = is_add | is_sub | is_and | is_or | is_xor | is_addi | is_lu12i
               | is_ld | is_st | is_beq | is_bne | is_b;

  // stores and compares read rd as second source
  assign src2_is_rd = is_st | is_beq | is_bne;
  assign rf_raddr1  = rj;
  assign rf_raddr2  = src2_is_rd ? rd : rk;

  always_comb begin
    id_ex_d.valid       = if_id.valid && known;
    id_ex_d.pc          = if_id.pc;
    id_ex_d.rj_val      = rf_rdata1;
    id_ex_d.rkd_val     = rf_rdata2;
    id_ex_d.rj          = rf_raddr1;
    id_ex_d.rs2         = rf_raddr2;
    id_ex_d.src2_is_imm = is_addi | is_lu12i | is_ld | is_st;
    id_ex_d.rf_we       = (is_add | is_sub | is_and | is_or | is_xor | is_addi
                          | is_lu12i | is_ld) && (rd != '0);
    id_ex_d.mem_we      = is_st;
    id_ex_d.load        = is_ld;
    id_ex_d.dest        = rd;

    if (is_lu12i) begin
      id_ex_d.imm = {inst[24:5], 12'b0};
    end else if (is_b) begin
      id_ex_d.imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
    end else if (is_beq || is_bne) begin
      id_ex_d.imm = {{14{inst[25]}}, inst[25:10], 2'b0};
    end else begin
      id_ex_d.imm = {{20{inst[21]}}, inst[21:10]};
    end

    id_ex_d.alu_op = alu_add;
    if (is_sub) id_ex_d.alu_op = alu_sub;
    if (is_and) id_ex_d.alu_op = alu_and;
    if (is_or) id_ex_d.alu_op = alu_or;
    if (is_xor) id_ex_d.alu_op = alu_xor;
    if (is_lu12i) id_ex_d.alu_op = alu_lui;

    id_ex_d.br_kind = br_none;
    if (is_beq) id_ex_d.br_kind = br_beq;
    if (is_bne) id_ex_d.br_kind = br_bne;
    if (is_b) id_ex_d.br_kind = br_b;
  end

  always_ff @(posedge clk) begin
    id_ex <= id_ex_d;
    if (reset || flush || bubble) begin
      id_ex.valid <= 1'b0;
    end
  end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter cpu_pkg::word_t reset_pc = 32'h1c000000
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            flush,
  input  logic            br_taken,
  input  cpu_pkg::word_t  br_target,
  output cpu_pkg::word_t  imem_addr,
  input  cpu_pkg::word_t  imem_data,
  output cpu_pkg::if_id_t if_id
);
  import cpu_pkg::*;

  word_t pc;
  word_t seq_pc;
  word_t next_pc;

  assign seq_pc    = pc + 32'd4;
  assign imem_addr = pc;

  // redirect wins over a held pc
  always_comb begin
    if (br_taken) begin
      next_pc = br_target;
    end else if (stall) begin
      next_pc = pc;
    end else begin
      next_pc = seq_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.inst  <= imem_data;
    end
  end

  // branch targets from execute must keep the pc aligned
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_lui
  } alu_op_e;

  // bits 31..15 of each encoding, free fields left at zero
  localparam logic [16:0] op_add_w   = 17'b000000_0000_01_00000;
  localparam logic [16:0] op_sub_w   = 17'b000000_0000_01_00010;
  localparam logic [16:0] op_and     = 17'b000000_0000_01_01001;
  localparam logic [16:0] op_or      = 17'b000000_0000_01_01010;
  localparam logic [16:0] op_xor     = 17'b000000_0000_01_01011;
  localparam logic [16:0] op_addi_w  = 17'b000000_1010_00_00000;
  localparam logic [16:0] op_lu12i_w = 17'b000101_0000_00_00000;
  localparam logic [16:0] op_ld_w    = 17'b001010_0010_00_00000;
  localparam logic [16:0] op_st_w    = 17'b001010_0110_00_00000;
  localparam logic [16:0] op_beq     = 17'b010110_0000_00_00000;
  localparam logic [16:0] op_bne     = 17'b010111_0000_00_00000;
  localparam logic [16:0] op_b       = 17'b010100_0000_00_00000;

  typedef logic [1:0] br_kind_t;
  localparam br_kind_t br_none = 2'd0;
  localparam br_kind_t br_beq  = 2'd1;
  localparam br_kind_t br_bne  = 2'd2;
  localparam br_kind_t br_b    = 2'd3;

  // operand source for the execute stage
  typedef logic [1:0] fwd_sel_e;
  localparam fwd_sel_e fwd_rf  = 2'd0;
  localparam fwd_sel_e fwd_mem = 2'd1;
  localparam fwd_sel_e fwd_wb  = 2'd2;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     rj_val;
    word_t     rkd_val;
    reg_addr_t rj;
    reg_addr_t rs2;
    word_t     imm;
    alu_op_e   alu_op;
    logic      src2_is_imm;
    logic      rf_we;
    logic      mem_we;
    logic      load;
    br_kind_t  br_kind;
    reg_addr_t dest;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     result;
    word_t     st_data;
    logic      rf_we;
    logic      mem_we;
    logic      load;
    reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     result;
    logic      rf_we;
    reg_addr_t dest;
  } mem_wb_t;

  typedef struct packed {
    logic  we;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic      we;
    word_t     pc;
    reg_addr_t wnum;
    word_t     wdata;
  } trace_t;

endpackage
